// ==== hdl/sq_segmenter.sv ====
module sq_segmenter #(
  parameter int LOG_MTU = 12
) (
  input  logic                         axis_aclk_i,
  input  logic                         axis_rstn_i,
  input  logic                         wqe_valid_i,
  input  wq_pkg::wqe_u                 wqe_i,
  output logic                         wqe_take_o,
  input  logic [wq_pkg::req_qpn_w-1:0] seg_qpn_i,
  output logic                         seg_done_o,
  output logic                         sq_valid_o,
  input  logic                         sq_ready_i,
  output logic [7:0]                   sq_opcode_o,
  output logic [wq_pkg::req_qpn_w-1:0] sq_qpn_o,
  output logic                         sq_last_o,
  output logic [wq_pkg::addr_w-1:0]    sq_remote_vaddr_o,
  output logic [wq_pkg::addr_w-1:0]    sq_local_vaddr_o,
  output logic [wq_pkg::len_w-1:0]     sq_len_o
);

  localparam logic [wq_pkg::len_w-1:0]  mtu      = wq_pkg::len_w'(1) << LOG_MTU;
  localparam logic [wq_pkg::addr_w-1:0] mtu_addr = wq_pkg::addr_w'(mtu);

  typedef enum logic {
    seg_idle,
    seg_emit
  } seg_state_e;

  seg_state_e                   state_q;

  // running position inside the current wqe
  logic [7:0]                   kind_q;
  logic [wq_pkg::len_w-1:0]     rem_len_q;
  logic [wq_pkg::addr_w-1:0]    laddr_q;
  logic [wq_pkg::addr_w-1:0]    raddr_q;

  // request on the sq port
  logic [7:0]                   opcode_q;
  logic [wq_pkg::req_qpn_w-1:0] qpn_q;
  logic                         last_q;
  logic [wq_pkg::addr_w-1:0]    req_raddr_q;
  logic [wq_pkg::addr_w-1:0]    req_laddr_q;
  logic [wq_pkg::len_w-1:0]     req_len_q;

  logic                         first;
  logic                         known;
  logic                         load;
  logic                         advance;
  logic [7:0]                   src_kind;
  logic [wq_pkg::len_w-1:0]     src_len;
  logic [wq_pkg::addr_w-1:0]    src_laddr;
  logic [wq_pkg::addr_w-1:0]    src_raddr;
  logic                         fits;
  logic                         req_last;
  logic [wq_pkg::len_w-1:0]     req_len;
  logic [7:0]                   req_opcode;

  ////////////////////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////////////////////

  assign first   = (state_q == seg_idle);
  assign known   = (wqe_i.msg.kind == wq_pkg::kind_write) ||
                   (wqe_i.msg.kind == wq_pkg::kind_send) ||
                   (wqe_i.msg.kind == wq_pkg::kind_read);

  assign wqe_take_o = first && wqe_valid_i;
  assign load       = wqe_take_o && known;
  assign advance    = (state_q == seg_emit) && sq_ready_i && !last_q;
  // unknown kinds are taken and retired without a request
  assign seg_done_o = ((state_q == seg_emit) && sq_ready_i && last_q) ||
                      (wqe_take_o && !known);

  always_comb begin
    if (first) begin
      src_kind  = wqe_i.msg.kind;
      src_len   = wqe_i.msg.len;
      src_laddr = wqe_i.msg.laddr;
      // a send has no remote address, its upper word is reserved
      if (wqe_i.msg.kind == wq_pkg::kind_send) begin
        src_raddr = '0;
      end else begin
        src_raddr = wqe_i.mem.rvaddr;
      end
    end else begin
      src_kind  = kind_q;
      src_len   = rem_len_q;
      src_laddr = laddr_q;
      src_raddr = raddr_q;
    end

    fits     = (src_len <= mtu);
    req_last = fits || (src_kind == wq_pkg::kind_read);
    req_len  = req_last ? src_len : mtu;

    case (src_kind)
      wq_pkg::kind_write: begin
        if (first) begin
          req_opcode = fits ? wq_pkg::rc_rdma_write_only : wq_pkg::rc_rdma_write_first;
        end else begin
          req_opcode = fits ? wq_pkg::rc_rdma_write_last : wq_pkg::rc_rdma_write_middle;
        end
      end
      wq_pkg::kind_send: begin
        if (first) begin
          req_opcode = fits ? wq_pkg::rc_send_only : wq_pkg::rc_send_first;
        end else begin
          req_opcode = fits ? wq_pkg::rc_send_last : wq_pkg::rc_send_middle;
        end
      end
      default: req_opcode = wq_pkg::rc_rdma_read_request;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and request registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= seg_idle;
    end else begin
      case (state_q)
        seg_idle: begin
          if (load) begin
            state_q <= seg_emit;
          end
        end
        seg_emit: begin
          if (sq_ready_i && last_q) begin
            state_q <= seg_idle;
          end
        end
        default: state_q <= seg_idle;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (load || advance) begin
      opcode_q    <= req_opcode;
      last_q      <= req_last;
      req_len_q   <= req_len;
      req_laddr_q <= src_laddr;
      req_raddr_q <= src_raddr;
      rem_len_q   <= src_len - mtu;
      laddr_q     <= src_laddr + mtu_addr;
      raddr_q     <= (src_kind == wq_pkg::kind_send) ? '0 : src_raddr + mtu_addr;
    end
    if (load) begin
      kind_q <= src_kind;
      qpn_q  <= seg_qpn_i;
    end
  end

  assign sq_valid_o        = (state_q == seg_emit);
  assign sq_opcode_o       = opcode_q;
  assign sq_qpn_o          = qpn_q;
  assign sq_last_o         = last_q;
  assign sq_remote_vaddr_o = req_raddr_q;
  assign sq_local_vaddr_o  = req_laddr_q;
  assign sq_len_o          = req_len_q;

endmodule

// ==== hdl/wq_doorbell_regs.sv ====
module wq_doorbell_regs #(
  parameter int DB_DEPTH = 8
) (
  input  logic                      axis_aclk_i,
  input  logic                      axis_rstn_i,
  input  logic                      db_write_i,
  input  logic [wq_pkg::qpn_w-1:0]  db_qpn_i,
  input  logic [wq_pkg::addr_w-1:0] db_sq_base_i,
  input  logic [wq_pkg::idx_w-1:0]  db_prod_idx_i,
  input  logic [wq_pkg::idx_w-1:0]  db_head_idx_i,
  input  logic                      db_pop_i,
  output logic                      db_avail_o,
  output logic [wq_pkg::qpn_w-1:0]  db_qpn_o,
  output logic [wq_pkg::addr_w-1:0] db_sq_base_o,
  output logic [wq_pkg::idx_w-1:0]  db_prod_idx_o,
  output logic [wq_pkg::idx_w-1:0]  db_head_idx_o
);

  localparam int ptr_w = (DB_DEPTH > 1) ? $clog2(DB_DEPTH) : 1;
  localparam int cnt_w = $clog2(DB_DEPTH + 1);

  logic [wq_pkg::qpn_w-1:0]  qpn_mem  [DB_DEPTH];
  logic [wq_pkg::addr_w-1:0] base_mem [DB_DEPTH];
  logic [wq_pkg::idx_w-1:0]  prod_mem [DB_DEPTH];
  logic [wq_pkg::idx_w-1:0]  head_mem [DB_DEPTH];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             push;
  logic             pop;

  // wrap for depths that are not a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(DB_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // doorbells that hit a full queue are lost
  assign push = db_write_i && (count_q != cnt_w'(DB_DEPTH));
  assign pop  = db_pop_i && (count_q != '0);

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (push) begin
      qpn_mem[wr_ptr_q]  <= db_qpn_i;
      base_mem[wr_ptr_q] <= db_sq_base_i;
      prod_mem[wr_ptr_q] <= db_prod_idx_i;
      head_mem[wr_ptr_q] <= db_head_idx_i;
    end
  end

  // oldest entry
  assign db_avail_o    = (count_q != '0);
  assign db_qpn_o      = qpn_mem[rd_ptr_q];
  assign db_sq_base_o  = base_mem[rd_ptr_q];
  assign db_prod_idx_o = prod_mem[rd_ptr_q];
  assign db_head_idx_o = head_mem[rd_ptr_q];

endmodule

// ==== hdl/wq_manager.sv ====
module wq_manager #(
  parameter int LOG_MTU  = 12,
  parameter int DB_DEPTH = 8
) (
  input  logic                          axis_aclk_i,
  input  logic                          axis_rstn_i,

  input  logic                          db_write_i,
  input  logic [wq_pkg::qpn_w-1:0]      db_qpn_i,
  input  logic [wq_pkg::addr_w-1:0]     db_sq_base_i,
  input  logic [wq_pkg::idx_w-1:0]      db_prod_idx_i,
  input  logic [wq_pkg::idx_w-1:0]      db_head_idx_i,

  output logic                          m_axi_arvalid_o,
  input  logic                          m_axi_arready_i,
  output logic [wq_pkg::addr_w-1:0]     m_axi_araddr_o,
  input  logic                          m_axi_rvalid_i,
  output logic                          m_axi_rready_o,
  input  logic [wq_pkg::axi_data_w-1:0] m_axi_rdata_i,
  input  logic                          m_axi_rlast_i,

  output logic                          sq_valid_o,
  input  logic                          sq_ready_i,
  output logic [7:0]                    sq_opcode_o,
  output logic [wq_pkg::req_qpn_w-1:0]  sq_qpn_o,
  output logic                          sq_last_o,
  output logic [wq_pkg::addr_w-1:0]     sq_remote_vaddr_o,
  output logic [wq_pkg::addr_w-1:0]     sq_local_vaddr_o,
  output logic [wq_pkg::len_w-1:0]      sq_len_o
);

  logic                         db_avail;
  logic [wq_pkg::qpn_w-1:0]     db_qpn;
  logic [wq_pkg::addr_w-1:0]    db_sq_base;
  logic [wq_pkg::idx_w-1:0]     db_prod_idx;
  logic [wq_pkg::idx_w-1:0]     db_head_idx;
  logic                         db_pop;
  logic                         fetch_req;
  logic [wq_pkg::addr_w-1:0]    fetch_addr;
  logic                         fetch_busy;
  logic                         wqe_valid;
  wq_pkg::wqe_u                 wqe;
  logic                         wqe_take;
  logic [wq_pkg::req_qpn_w-1:0] seg_qpn;
  logic                         seg_done;

  ////////////////////////////////////////////////////////////////////////////
  // doorbell queue and index walk
  ////////////////////////////////////////////////////////////////////////////

  wq_doorbell_regs #(
    .DB_DEPTH(DB_DEPTH)
  ) u_doorbell_regs (
    .axis_aclk_i  (axis_aclk_i),
    .axis_rstn_i  (axis_rstn_i),
    .db_write_i   (db_write_i),
    .db_qpn_i     (db_qpn_i),
    .db_sq_base_i (db_sq_base_i),
    .db_prod_idx_i(db_prod_idx_i),
    .db_head_idx_i(db_head_idx_i),
    .db_pop_i     (db_pop),
    .db_avail_o   (db_avail),
    .db_qpn_o     (db_qpn),
    .db_sq_base_o (db_sq_base),
    .db_prod_idx_o(db_prod_idx),
    .db_head_idx_o(db_head_idx)
  );

  wq_sequencer u_sequencer (
    .axis_aclk_i  (axis_aclk_i),
    .axis_rstn_i  (axis_rstn_i),
    .db_avail_i   (db_avail),
    .db_qpn_i     (db_qpn),
    .db_sq_base_i (db_sq_base),
    .db_prod_idx_i(db_prod_idx),
    .db_head_idx_i(db_head_idx),
    .fetch_busy_i (fetch_busy),
    .seg_done_i   (seg_done),
    .db_pop_o     (db_pop),
    .fetch_req_o  (fetch_req),
    .fetch_addr_o (fetch_addr),
    .seg_qpn_o    (seg_qpn)
  );

  ////////////////////////////////////////////////////////////////////////////
  // wqe fetch and segmentation
  ////////////////////////////////////////////////////////////////////////////

  wqe_axi_reader u_reader (
    .axis_aclk_i    (axis_aclk_i),
    .axis_rstn_i    (axis_rstn_i),
    .fetch_req_i    (fetch_req),
    .fetch_addr_i   (fetch_addr),
    .fetch_busy_o   (fetch_busy),
    .m_axi_arvalid_o(m_axi_arvalid_o),
    .m_axi_arready_i(m_axi_arready_i),
    .m_axi_araddr_o (m_axi_araddr_o),
    .m_axi_rvalid_i (m_axi_rvalid_i),
    .m_axi_rready_o (m_axi_rready_o),
    .m_axi_rdata_i  (m_axi_rdata_i),
    .m_axi_rlast_i  (m_axi_rlast_i),
    .wqe_valid_o    (wqe_valid),
    .wqe_o          (wqe),
    .wqe_take_i     (wqe_take)
  );

  sq_segmenter #(
    .LOG_MTU(LOG_MTU)
  ) u_segmenter (
    .axis_aclk_i      (axis_aclk_i),
    .axis_rstn_i      (axis_rstn_i),
    .wqe_valid_i      (wqe_valid),
    .wqe_i            (wqe),
    .wqe_take_o       (wqe_take),
    .seg_qpn_i        (seg_qpn),
    .seg_done_o       (seg_done),
    .sq_valid_o       (sq_valid_o),
    .sq_ready_i       (sq_ready_i),
    .sq_opcode_o      (sq_opcode_o),
    .sq_qpn_o         (sq_qpn_o),
    .sq_last_o        (sq_last_o),
    .sq_remote_vaddr_o(sq_remote_vaddr_o),
    .sq_local_vaddr_o (sq_local_vaddr_o),
    .sq_len_o         (sq_len_o)
  );

endmodule

// ==== hdl/wq_pkg.sv ====
package wq_pkg;

  // widths
  localparam int addr_w     = 64;
  localparam int idx_w      = 32;
  localparam int qpn_w      = 8;
  localparam int req_qpn_w  = 24;
  localparam int len_w      = 32;
  localparam int wqe_w      = 256;
  localparam int axi_data_w = 512;

  // each wqe takes 64 bytes in the send queue
  localparam int wqe_bytes_log2 = 6;

  // wqe kind codes
  localparam logic [7:0] kind_write = 8'h00;
  localparam logic [7:0] kind_send  = 8'h02;
  localparam logic [7:0] kind_read  = 8'h04;

  // roce rc opcodes
  localparam logic [7:0] rc_send_first        = 8'h00;
  localparam logic [7:0] rc_send_middle       = 8'h01;
  localparam logic [7:0] rc_send_last         = 8'h02;
  localparam logic [7:0] rc_send_only         = 8'h04;
  localparam logic [7:0] rc_rdma_write_first  = 8'h06;
  localparam logic [7:0] rc_rdma_write_middle = 8'h07;
  localparam logic [7:0] rc_rdma_write_last   = 8'h08;
  localparam logic [7:0] rc_rdma_write_only   = 8'h0A;
  localparam logic [7:0] rc_rdma_read_request = 8'h0C;

  // memory view, for rdma write and read
  typedef struct packed {
    logic [31:0]       rkey;
    logic [63:0]       rvaddr;
    logic [23:0]       rsvd_hi;
    logic [7:0]        kind;
    logic [len_w-1:0]  len;
    logic [addr_w-1:0] laddr;
    logic [15:0]       rsvd_lo;
    logic [15:0]       wr_id;
  } wqe_mem_t;

  // message view, for send
  typedef struct packed {
    logic [95:0]       rsvd_msg;
    logic [23:0]       rsvd_hi;
    logic [7:0]        kind;
    logic [len_w-1:0]  len;
    logic [addr_w-1:0] laddr;
    logic [15:0]       rsvd_lo;
    logic [15:0]       wr_id;
  } wqe_msg_t;

  typedef union packed {
    wqe_mem_t mem;
    wqe_msg_t msg;
  } wqe_u;

endpackage

// ==== hdl/wq_sequencer.sv ====
module wq_sequencer (
  input  logic                         axis_aclk_i,
  input  logic                         axis_rstn_i,
  input  logic                         db_avail_i,
  input  logic [wq_pkg::qpn_w-1:0]     db_qpn_i,
  input  logic [wq_pkg::addr_w-1:0]    db_sq_base_i,
  input  logic [wq_pkg::idx_w-1:0]     db_prod_idx_i,
  input  logic [wq_pkg::idx_w-1:0]     db_head_idx_i,
  input  logic                         fetch_busy_i,
  input  logic                         seg_done_i,
  output logic                         db_pop_o,
  output logic                         fetch_req_o,
  output logic [wq_pkg::addr_w-1:0]    fetch_addr_o,
  output logic [wq_pkg::req_qpn_w-1:0] seg_qpn_o
);

  typedef enum logic [1:0] {
    seq_idle,
    seq_issue,
    seq_drain
  } seq_state_e;

  seq_state_e                      state_q;
  logic [wq_pkg::idx_w-1:0]        idx_q;
  logic [wq_pkg::idx_w-1:0]        idx_next;
  logic [wq_pkg::addr_w-1:0]       idx_ext;
  // fetched but not yet segmented, at most two
  logic [1:0]                      pending_q;
  logic [wq_pkg::req_qpn_w-1:0]    seg_qpn_q;
  logic                            has_work;

  // sanity check, an empty doorbell is popped right away
  assign has_work = (db_prod_idx_i > db_head_idx_i);
  assign idx_next = idx_q + 1'b1;
  assign idx_ext  = {{(wq_pkg::addr_w - wq_pkg::idx_w){1'b0}}, idx_q};

  assign fetch_req_o  = (state_q == seq_issue) && !fetch_busy_i;
  assign fetch_addr_o = db_sq_base_i + (idx_ext << wq_pkg::wqe_bytes_log2);
  assign db_pop_o     = ((state_q == seq_idle) && db_avail_i && !has_work) ||
                        ((state_q == seq_drain) && (pending_q == '0));
  assign seg_qpn_o    = seg_qpn_q;

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= seq_idle;
      idx_q   <= '0;
    end else begin
      case (state_q)
        seq_idle: begin
          if (db_avail_i && has_work) begin
            idx_q   <= db_head_idx_i;
            state_q <= seq_issue;
          end
        end
        seq_issue: begin
          if (fetch_req_o) begin
            idx_q <= idx_next;
            if (idx_next == db_prod_idx_i) begin
              state_q <= seq_drain;
            end
          end
        end
        seq_drain: begin
          // doorbell leaves the queue once every wqe is segmented
          if (pending_q == '0) begin
            state_q <= seq_idle;
          end
        end
        default: state_q <= seq_idle;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      pending_q <= '0;
    end else begin
      case ({fetch_req_o, seg_done_i})
        2'b10:   pending_q <= pending_q + 1'b1;
        2'b01:   pending_q <= pending_q - 1'b1;
        default: pending_q <= pending_q;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if ((state_q == seq_idle) && db_avail_i && has_work) begin
      seg_qpn_q <= {{(wq_pkg::req_qpn_w - wq_pkg::qpn_w){1'b0}}, db_qpn_i};
    end
  end

endmodule

// ==== hdl/wqe_axi_reader.sv ====
module wqe_axi_reader (
  input  logic                          axis_aclk_i,
  input  logic                          axis_rstn_i,
  input  logic                          fetch_req_i,
  input  logic [wq_pkg::addr_w-1:0]     fetch_addr_i,
  output logic                          fetch_busy_o,
  output logic                          m_axi_arvalid_o,
  input  logic                          m_axi_arready_i,
  output logic [wq_pkg::addr_w-1:0]     m_axi_araddr_o,
  input  logic                          m_axi_rvalid_i,
  output logic                          m_axi_rready_o,
  input  logic [wq_pkg::axi_data_w-1:0] m_axi_rdata_i,
  input  logic                          m_axi_rlast_i,
  output logic                          wqe_valid_o,
  output wq_pkg::wqe_u                  wqe_o,
  input  logic                          wqe_take_i
);

  typedef enum logic [1:0] {
    rd_idle,
    rd_addr,
    rd_data,
    rd_hold
  } rd_state_e;

  rd_state_e                 state_q;
  logic [wq_pkg::addr_w-1:0] araddr_q;
  wq_pkg::wqe_u              wqe_q;

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= rd_idle;
    end else begin
      case (state_q)
        rd_idle: begin
          if (fetch_req_i) begin
            state_q <= rd_addr;
          end
        end
        rd_addr: begin
          if (m_axi_arready_i) begin
            state_q <= rd_data;
          end
        end
        rd_data: begin
          if (m_axi_rvalid_i && m_axi_rlast_i) begin
            state_q <= rd_hold;
          end
        end
        rd_hold: begin
          // wait for the segmenter to pick the wqe up
          if (wqe_take_i) begin
            state_q <= rd_idle;
          end
        end
        default: state_q <= rd_idle;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if ((state_q == rd_idle) && fetch_req_i) begin
      araddr_q <= fetch_addr_i;
    end
    // wqe sits in the low half of the beat
    if ((state_q == rd_data) && m_axi_rvalid_i && m_axi_rlast_i) begin
      wqe_q <= m_axi_rdata_i[wq_pkg::wqe_w-1:0];
    end
  end

  assign fetch_busy_o    = (state_q != rd_idle);
  assign m_axi_arvalid_o = (state_q == rd_addr);
  assign m_axi_araddr_o  = araddr_q;
  assign m_axi_rready_o  = (state_q == rd_data);
  assign wqe_valid_o     = (state_q == rd_hold);
  assign wqe_o           = wqe_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module wq_manager_tb -f wq_manager.f -o wq_manager_sim \
  && ./obj_dir/wq_manager_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "simulation build or run failed"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release just after an edge so the first active cycle is clean
  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rstn_o = 1'b1;
  end

endmodule

// ==== verification/wq_axi_mem_model.sv ====
module wq_axi_mem_model #(
  parameter int SEED        = 32'h5c2c1043,
  parameter int RDY_TIMEOUT = 100
) (
  input  logic         clk_i,
  input  logic         rstn_i,
  input  logic         arvalid_i,
  output logic         arready_o,
  input  logic [63:0]  araddr_i,
  output logic         rvalid_o,
  input  logic         rready_i,
  output logic [511:0] rdata_o,
  output logic         rlast_o,
  input  logic [255:0] slots_i [16],
  output logic         stall_o
);

  integer      seed;
  int          delay;
  int          cycles;
  logic [63:0] addr;

  initial begin
    seed      = SEED;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rlast_o   = 1'b0;
    rdata_o   = '0;
    stall_o   = 1'b0;
    forever begin
      @(posedge clk_i);
      if (rstn_i && arvalid_i) begin
        // address accepted after 0 to 3 cycles
        delay = $random(seed) & 3;
        repeat (delay) @(posedge clk_i);
        #1;
        arready_o = 1'b1;
        @(posedge clk_i);
        addr = araddr_i;
        #1;
        arready_o = 1'b0;
        delay = 1 + ($random(seed) & 3);
        repeat (delay) @(posedge clk_i);
        #1;
        // slot from the index bits, upper half tags the beat with its address
        rdata_o  = {{4{addr}}, slots_i[addr[9:6]]};
        rvalid_o = 1'b1;
        rlast_o  = 1'b1;
        cycles   = 0;
        do begin
          @(posedge clk_i);
          cycles++;
        end while (!rready_i && cycles < RDY_TIMEOUT);
        if (!rready_i) begin
          stall_o = 1'b1;
        end
        #1;
        rvalid_o = 1'b0;
        rlast_o  = 1'b0;
      end
    end
  end

endmodule

// ==== verification/wq_manager_tb.sv ====
module wq_manager_tb;

  localparam int          log_mtu      = 8;
  localparam int          db_depth     = 4;
  localparam logic [31:0] mtu          = 32'd256;
  localparam int          num_tests    = 7;
  localparam int          req_timeout  = 2000;
  localparam int          rst_timeout  = 100;
  localparam int          quiet_cycles = 40;
  localparam int          seed_init    = 32'h5c2c1043;
  localparam logic [63:0] sq_base      = 64'h0000_0001_0000_0000;

  // wqe kinds
  localparam logic [7:0] k_write = 8'h00;
  localparam logic [7:0] k_send  = 8'h02;
  localparam logic [7:0] k_read  = 8'h04;

  // rc opcodes
  localparam logic [7:0] op_send_first   = 8'h00;
  localparam logic [7:0] op_send_middle  = 8'h01;
  localparam logic [7:0] op_send_last    = 8'h02;
  localparam logic [7:0] op_send_only    = 8'h04;
  localparam logic [7:0] op_write_first  = 8'h06;
  localparam logic [7:0] op_write_middle = 8'h07;
  localparam logic [7:0] op_write_last   = 8'h08;
  localparam logic [7:0] op_write_only   = 8'h0A;
  localparam logic [7:0] op_read_req     = 8'h0C;

  typedef struct packed {
    logic [7:0]  kind;
    logic [7:0]  qpn;
    logic [31:0] len;
    logic [63:0] laddr;
    logic [63:0] raddr;
    logic [31:0] head;
    logic [31:0] prod;
    logic [31:0] nwqe;
  } test_row_t;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [23:0] qpn;
    logic        last;
    logic [63:0] raddr;
    logic [63:0] laddr;
    logic [31:0] len;
  } sq_req_t;

  // kind, qpn, length, local, remote, head, producer, wqe count
  test_row_t table_rows [num_tests] = '{
    '{k_write, 8'h21, 32'd200,  64'h0000_5000, 64'h0009_0000, 32'd3, 32'd3, 32'd0},
    '{k_write, 8'h22, 32'd200,  64'h0000_1000, 64'h0008_0000, 32'd0, 32'd1, 32'd1},
    '{k_write, 8'h23, 32'd640,  64'h0000_2000, 64'h0008_4000, 32'd1, 32'd2, 32'd1},
    '{k_send,  8'h24, 32'd600,  64'h0000_3000, 64'h0008_8000, 32'd0, 32'd1, 32'd1},
    '{k_send,  8'h25, 32'd100,  64'h0000_3800, 64'h0008_c000, 32'd5, 32'd6, 32'd1},
    '{k_read,  8'h26, 32'd5000, 64'h0000_4000, 64'h000a_0000, 32'd0, 32'd1, 32'd1},
    '{k_write, 8'h27, 32'd300,  64'h0001_0000, 64'h0010_0000, 32'd2, 32'd5, 32'd3}
  };

  logic         clk;
  logic         rstn;
  logic         db_write;
  logic [7:0]   db_qpn;
  logic [63:0]  db_sq_base;
  logic [31:0]  db_prod_idx;
  logic [31:0]  db_head_idx;
  logic         arvalid;
  logic         arready;
  logic [63:0]  araddr;
  logic         rvalid;
  logic         rready;
  logic [511:0] rdata;
  logic         rlast;
  logic         sq_valid;
  logic         sq_ready;
  logic [7:0]   sq_opcode;
  logic [23:0]  sq_qpn;
  logic         sq_last;
  logic [63:0]  sq_raddr;
  logic [63:0]  sq_laddr;
  logic [31:0]  sq_len;
  logic         mem_stall;
  logic [255:0] wqe_mem [16];

  sq_req_t      exp_q [$];
  sq_req_t      got_q [$];
  logic [63:0]  ar_q [$];
  integer       seed;
  int           error_count;
  int           test_errors;
  int           pass_count;
  int           fail_count;
  int           cycles;
  int           t;

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(4)) u_clk (.clk_o(clk), .rstn_o(rstn));

  wq_axi_mem_model #(.SEED(seed_init)) u_mem (
    .clk_i(clk), .rstn_i(rstn), .arvalid_i(arvalid), .arready_o(arready),
    .araddr_i(araddr), .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata),
    .rlast_o(rlast), .slots_i(wqe_mem), .stall_o(mem_stall)
  );

  wq_manager #(.LOG_MTU(log_mtu), .DB_DEPTH(db_depth)) uut (
    .axis_aclk_i(clk), .axis_rstn_i(rstn),
    .db_write_i(db_write), .db_qpn_i(db_qpn), .db_sq_base_i(db_sq_base),
    .db_prod_idx_i(db_prod_idx), .db_head_idx_i(db_head_idx),
    .m_axi_arvalid_o(arvalid), .m_axi_arready_i(arready), .m_axi_araddr_o(araddr),
    .m_axi_rvalid_i(rvalid), .m_axi_rready_o(rready), .m_axi_rdata_i(rdata),
    .m_axi_rlast_i(rlast),
    .sq_valid_o(sq_valid), .sq_ready_i(sq_ready), .sq_opcode_o(sq_opcode),
    .sq_qpn_o(sq_qpn), .sq_last_o(sq_last), .sq_remote_vaddr_o(sq_raddr),
    .sq_local_vaddr_o(sq_laddr), .sq_len_o(sq_len)
  );

  ////////////////////////////////////////////////////////////////////////////
  // expected values from the segmentation rule
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] wqe_len(input test_row_t row, input int k);
    return row.len + 32'(k) * 32'd100;
  endfunction

  function automatic logic [63:0] wqe_laddr(input test_row_t row, input int k);
    return row.laddr + 64'(k) * 64'h1_0000;
  endfunction

  function automatic logic [63:0] wqe_raddr(input test_row_t row, input int k);
    return row.raddr + 64'(k) * 64'h1_0000;
  endfunction

  function automatic logic [255:0] make_wqe(input test_row_t row, input int k);
    logic [255:0] w;
    w          = '0;
    w[15:0]    = 16'h0100 + 16'(k);
    w[95:32]   = wqe_laddr(row, k);
    w[127:96]  = wqe_len(row, k);
    w[135:128] = row.kind;
    // a send still gets a nonzero upper word that must not show up
    w[223:160] = wqe_raddr(row, k);
    w[255:224] = 32'hbeef_0000 + 32'(k);
    return w;
  endfunction

  function automatic logic [7:0] rc_opcode(input logic [7:0] kind, input logic first,
                                           input logic last_seg);
    if (kind == k_send) begin
      if (last_seg) begin
        return first ? op_send_only : op_send_last;
      end
      return first ? op_send_first : op_send_middle;
    end
    if (last_seg) begin
      return first ? op_write_only : op_write_last;
    end
    return first ? op_write_first : op_write_middle;
  endfunction

  task automatic add_expected(input test_row_t row, input int k);
    logic [31:0] rem;
    logic [63:0] la;
    logic [63:0] ra;
    logic        first;
    logic        done;
    sq_req_t     r;
    rem   = wqe_len(row, k);
    la    = wqe_laddr(row, k);
    ra    = (row.kind == k_send) ? 64'd0 : wqe_raddr(row, k);
    first = 1'b1;
    done  = 1'b0;
    r.qpn = {16'd0, row.qpn};
    while (!done) begin
      r.laddr = la;
      r.raddr = ra;
      if (row.kind == k_read || rem <= mtu) begin
        r.opcode = (row.kind == k_read) ? op_read_req : rc_opcode(row.kind, first, 1'b1);
        r.last   = 1'b1;
        r.len    = rem;
        done     = 1'b1;
      end else begin
        r.opcode = rc_opcode(row.kind, first, 1'b0);
        r.last   = 1'b0;
        r.len    = mtu;
        rem      = rem - mtu;
        la       = la + 64'(mtu);
        if (row.kind != k_send) begin
          ra = ra + 64'(mtu);
        end
      end
      exp_q.push_back(r);
      first = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus, monitor and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic sq_req_t observed_req();
    sq_req_t r;
    r.opcode = sq_opcode;
    r.qpn    = sq_qpn;
    r.last   = sq_last;
    r.raddr  = sq_raddr;
    r.laddr  = sq_laddr;
    r.len    = sq_len;
    return r;
  endfunction

  // handshakes as the DUT sees them at the edge
  always @(posedge clk) begin
    if (arvalid && arready) begin
      ar_q.push_back(araddr);
    end
    if (sq_valid && sq_ready) begin
      got_q.push_back(observed_req());
    end
  end

  // random back-pressure with ready about three cycles in four
  initial begin
    seed     = seed_init;
    sq_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      sq_ready = (($random(seed) & 3) != 0);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%0h, expected 0x%0h", name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic compare_req(input int i, input sq_req_t got, input sq_req_t exp);
    check_value($sformatf("sq_opcode_o[%0d]", i), 64'(got.opcode), 64'(exp.opcode));
    check_value($sformatf("sq_qpn_o[%0d]", i), 64'(got.qpn), 64'(exp.qpn));
    check_value($sformatf("sq_last_o[%0d]", i), 64'(got.last), 64'(exp.last));
    check_value($sformatf("sq_remote_vaddr_o[%0d]", i), got.raddr, exp.raddr);
    check_value($sformatf("sq_local_vaddr_o[%0d]", i), got.laddr, exp.laddr);
    check_value($sformatf("sq_len_o[%0d]", i), 64'(got.len), 64'(exp.len));
  endtask

  task automatic ring_doorbell(input test_row_t row);
    @(posedge clk);
    #1;
    db_write    = 1'b1;
    db_qpn      = row.qpn;
    db_sq_base  = sq_base;
    db_prod_idx = row.prod;
    db_head_idx = row.head;
    @(posedge clk);
    #1;
    db_write = 1'b0;
  endtask

  task automatic run_test(input int num);
    test_row_t row;
    int        k;
    int        n;
    int        wait_cycles;
    row         = table_rows[num];
    test_errors = 0;
    exp_q.delete();
    got_q.delete();
    ar_q.delete();
    for (k = 0; k < int'(row.nwqe); k++) begin
      wqe_mem[4'(row.head + 32'(k))] = make_wqe(row, k);
      add_expected(row, k);
    end
    ring_doorbell(row);
    wait_cycles = 0;
    while (got_q.size() < exp_q.size() && wait_cycles < req_timeout) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (got_q.size() < exp_q.size()) begin
      $display("timeout: test %0d got %0d of %0d requests within %0d cycles",
               num, got_q.size(), exp_q.size(), req_timeout);
      test_errors++;
    end
    // nothing beyond the expected requests may follow
    repeat (quiet_cycles) @(posedge clk);
    #1;
    check_value("request count", 64'(got_q.size()), 64'(exp_q.size()));
    check_value("m_axi_araddr_o count", 64'(ar_q.size()), 64'(row.nwqe));
    for (k = 0; k < ar_q.size() && k < int'(row.nwqe); k++) begin
      check_value($sformatf("m_axi_araddr_o[%0d]", k), ar_q[k],
                  sq_base + 64'(row.head + 32'(k)) * 64'd64);
    end
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (k = 0; k < n; k++) begin
      compare_req(k, got_q[k], exp_q[k]);
    end
    if (test_errors == 0) begin
      pass_count++;
      $display("test %0d kind 0x%02h, %0d requests: ok", num, row.kind, got_q.size());
    end else begin
      fail_count++;
      $display("test %0d kind 0x%02h: failed with %0d errors", num, row.kind, test_errors);
    end
  endtask

  initial begin
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    db_write    = 1'b0;
    db_qpn      = '0;
    db_sq_base  = '0;
    db_prod_idx = '0;
    db_head_idx = '0;
    for (t = 0; t < 16; t++) begin
      wqe_mem[t] = {4{sq_base + 64'(t) * 64'd64}};
    end
    cycles = 0;
    while (!rstn && cycles < rst_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (!rstn) begin
      $display("reset was never released");
      error_count++;
    end
    repeat (2) @(posedge clk);
    #1;
    check_value("sq_valid_o", 64'(sq_valid), 64'd0);
    check_value("m_axi_arvalid_o", 64'(arvalid), 64'd0);
    check_value("m_axi_rready_o", 64'(rready), 64'd0);
    for (t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    if (mem_stall) begin
      $display("memory model: read data was never accepted");
      error_count++;
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             num_tests, pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== wq_manager.f ====
hdl/wq_pkg.sv
hdl/wq_doorbell_regs.sv
hdl/wq_sequencer.sv
hdl/wqe_axi_reader.sv
hdl/sq_segmenter.sv
hdl/wq_manager.sv
verification/tb_clock_gen.sv
verification/wq_axi_mem_model.sv
verification/wq_manager_tb.sv
